/* design/corr_macros.svh */
// Sizing and APB layout constants for the one-bit correlator
// Lags run from -(CORR_LAG_CROSS-1) to +(CORR_LAG_CROSS-1)
// Result words are read-only and sit after the four control registers

`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Correlator geometry
`define CORR_NUM_INPUTS     4
`define CORR_LAG_CROSS      2
`define CORR_NUM_LAGS       (2*`CORR_LAG_CROSS-1)
`define CORR_DEPTH          (2*`CORR_LAG_CROSS-1)
`define CORR_NUM_BASELINES  6
`define CORR_NUM_RESULTS    (`CORR_NUM_BASELINES*`CORR_NUM_LAGS)
`define CORR_COUNT_W        16

// ~~~~~~~~~~~~~~~~~~~~
// APB layout
`define CORR_APB_ADDR_W     8
`define CORR_APB_DATA_W     32
`define CORR_RESULT_BASE    8'h40
`define CORR_CTRL_EN_BIT    0
`define CORR_CTRL_CLR_BIT   1
`define CORR_STAT_RDY_BIT   0

`endif

/* design/corr_pkg.sv */
// Types shared by the correlator RTL
// Result index is baseline*CORR_NUM_LAGS + (lag+1)
// Baselines go (0,1),(0,2),(0,3),(1,2),(1,3),(2,3)

`include "corr_macros.svh"

package corr_pkg;

	// One coincidence count, also used for the integration length
	typedef logic [`CORR_COUNT_W-1:0] count_t;

	// Selects one word of the result bank
	typedef logic [$clog2(`CORR_NUM_RESULTS)-1:0] result_idx_t;

	// Delay-line taps, [line][age] with age 0 the newest sample
	typedef logic [`CORR_NUM_INPUTS-1:0][`CORR_DEPTH-1:0] tap_array_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// APB register offsets
	typedef enum logic [`CORR_APB_ADDR_W-1:0] {
		CTRL        = 8'h00, // bit0 enable, bit1 clear (self clearing)
		INT_LEN     = 8'h04, // Samples per frame, 0 never ends
		STATUS      = 8'h08, // bit0 sticky frame_ready, write 1 to clear
		FRAME_COUNT = 8'h0C  // Frames done since reset or clear
	} reg_addr_e;

endpackage

/* design/sample_if.sv */
// Delay-line taps and their valid strobe, capture side to accumulator
// valid is high for one cycle per captured sample

`timescale 1ns/10ps

`include "corr_macros.svh"

interface sample_if
	import corr_pkg::*;
();

	tap_array_t taps; // Snapshot of all delay lines
	logic       valid; // New sample shifted in last edge

	modport capture (
		output taps,
		output valid
	);

	modport accum (
		input taps,
		input valid
	);

endinterface

/* design/result_if.sv */
// Control, frame events and result read port between core and registers
// rd_count follows rd_index combinationally

`timescale 1ns/10ps

`include "corr_macros.svh"

interface result_if
	import corr_pkg::*;
();

	logic        enable;
	count_t      int_len;
	logic        clear_pulse; // One cycle
	result_idx_t rd_index;
	count_t      rd_count;
	logic        frame_done; // One cycle after the bank loads

	modport core (
		input  enable, int_len, clear_pulse, rd_index,
		output rd_count, frame_done
	);

	modport regs (
		output enable, int_len, clear_pulse, rd_index,
		input  rd_count, frame_done
	);

endinterface

/* design/sample_capture.sv */
// Input delay lines, one per line, shifted on each sample strobe
// Inputs must already be synchronous to clk
// Lines keep shifting regardless of the accumulator enable

`timescale 1ns/10ps

`include "corr_macros.svh"

module sample_capture
	import corr_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`CORR_NUM_INPUTS-1:0] samples,
	input  logic                        sample_valid,
	sample_if.capture                   cap
);

	tap_array_t lines;
	logic       valid_q;

	always_ff @(posedge clk) begin
		if (!reset) begin
			lines   <= '0; // Known history for the first lags
			valid_q <= 1'b0;
		end else begin
			valid_q <= sample_valid;
			if (sample_valid) begin
				for (int i = 0; i < `CORR_NUM_INPUTS; i++) begin
					// Newest at age 0, oldest falls off the top
					lines[i] <= {lines[i][`CORR_DEPTH-2:0], samples[i]};
				end
			end
		end
	end

	assign cap.taps  = lines;
	assign cap.valid = valid_q;

	// ~~~~~~~~~~~~~~~~~~~~
	// Strobed sign bits must be known before they enter the lines
	a_samples_known: assert property (
		@(posedge clk) disable iff (!reset)
		sample_valid |-> !$isunknown(samples)
	);

endmodule

/* design/lag_accumulator.sv */
// Coincidence counters for every baseline and lag, plus frame control
// Counters can wrap if int_len exceeds the counter range
// Lowering int_len below the running count mid-frame delays the frame end

`timescale 1ns/10ps

`include "corr_macros.svh"

module lag_accumulator
	import corr_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	sample_if.accum smp,
	result_if.core  res
);

	localparam int NUM_IN  = `CORR_NUM_INPUTS;
	localparam int NUM_RES = `CORR_NUM_RESULTS;
	localparam int MID     = `CORR_LAG_CROSS - 1; // Age of the reference tap

	logic [NUM_RES-1:0] agree;
	count_t             counters [NUM_RES];
	count_t             bank [NUM_RES];
	count_t             int_count;
	count_t             int_next;
	logic               count_en;
	logic               frame_end;
	logic               frame_done_q;

	// ~~~~~~~~~~~~~~~~~~~~
	// Coincidence per baseline and lag
	for (genvar i = 0; i < NUM_IN; i++) begin : g_line_a
		for (genvar j = i + 1; j < NUM_IN; j++) begin : g_line_b
			// Pairs are numbered in row order of the upper triangle
			localparam int base_idx = i*(2*NUM_IN - i - 1)/2 + (j - i - 1);
			for (genvar l = 0; l < `CORR_NUM_LAGS; l++) begin : g_lag
				// Lag l-MID compares line i at MID with line j at age l
				assign agree[base_idx*`CORR_NUM_LAGS + l] =
					(smp.taps[i][MID] == smp.taps[j][l]);
			end
		end
	end

	assign count_en  = smp.valid && res.enable;
	assign int_next  = int_count + 1'b1;
	assign frame_end = count_en && !res.clear_pulse &&
	                   (res.int_len != '0) && (int_next == res.int_len);

	// ~~~~~~~~~~~~~~~~~~~~
	// Counters, integration count and bank
	always_ff @(posedge clk) begin
		if (!reset) begin
			int_count    <= '0;
			frame_done_q <= 1'b0;
			for (int r = 0; r < NUM_RES; r++) begin
				counters[r] <= '0;
				bank[r]     <= '0;
			end
		end else begin
			frame_done_q <= frame_end;
			if (res.clear_pulse) begin
				int_count <= '0;
				for (int r = 0; r < NUM_RES; r++) begin
					counters[r] <= '0;
				end
			end else if (count_en) begin
				int_count <= frame_end ? count_t'(0) : int_next;
				for (int r = 0; r < NUM_RES; r++) begin
					if (frame_end) begin
						bank[r]     <= counters[r] + count_t'(agree[r]); // Include last sample
						counters[r] <= '0;
					end else begin
						counters[r] <= counters[r] + count_t'(agree[r]);
					end
				end
			end
		end
	end

	assign res.frame_done = frame_done_q;
	assign res.rd_count   = (res.rd_index < NUM_RES) ? bank[res.rd_index] : '0;

	// ~~~~~~~~~~~~~~~~~~~~
	for (genvar r = 0; r < NUM_RES; r++) begin : g_bound_chk
		a_count_bound: assert property (
			@(posedge clk) disable iff (!reset)
			(res.int_len != '0) |-> (counters[r] <= res.int_len)
		);
	end

	// Single-sample frames may legally end on consecutive cycles
	a_frame_done_pulse: assert property (
		@(posedge clk) disable iff (!reset)
		(res.frame_done && (res.int_len != count_t'(1))) |=> !res.frame_done
	);

endmodule

/* design/apb_readout.sv */
// APB slave for control, status, frame count and result bank
// Zero wait states; result window is read-only and writes there are dropped
// Register offsets must match exactly, result words ignore paddr[1:0]

`timescale 1ns/10ps

`include "corr_macros.svh"

module apb_readout
	import corr_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`CORR_APB_ADDR_W-1:0] paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [`CORR_APB_DATA_W-1:0] pwdata,
	output logic [`CORR_APB_DATA_W-1:0] prdata,
	output logic                        pready,
	output logic                        pslverr,
	result_if.regs                      res
);

	reg_addr_e                   reg_sel;
	logic [`CORR_APB_ADDR_W-1:0] win_off;
	logic                        access;
	logic                        wr_en;
	logic                        is_reg;
	logic                        in_window;

	logic                        enable_q;
	count_t                      int_len_q;
	logic                        clear_q;
	logic                        frame_ready;
	logic [`CORR_APB_DATA_W-1:0] frame_count;

	// ~~~~~~~~~~~~~~~~~~~~
	// Address decode
	assign reg_sel   = reg_addr_e'(paddr);
	assign win_off   = paddr - `CORR_RESULT_BASE;
	assign in_window = (paddr >= `CORR_RESULT_BASE) && (win_off[7:2] < `CORR_NUM_RESULTS);
	assign access    = psel && penable;
	assign wr_en     = access && pwrite;

	always_comb begin
		case (reg_sel)
			CTRL, INT_LEN, STATUS, FRAME_COUNT: is_reg = 1'b1;
			default:                            is_reg = 1'b0;
		endcase
	end

	assign pready       = access;
	assign pslverr      = access && !is_reg && !in_window;
	assign res.rd_index = result_idx_t'(win_off[7:2]);

	// Read mux
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (reg_sel)
				CTRL:        prdata[`CORR_CTRL_EN_BIT] = enable_q; // Clear bit reads 0
				INT_LEN:     prdata = `CORR_APB_DATA_W'(int_len_q);
				STATUS:      prdata[`CORR_STAT_RDY_BIT] = frame_ready;
				FRAME_COUNT: prdata = frame_count;
				default: begin
					if (in_window) begin
						prdata = `CORR_APB_DATA_W'(res.rd_count);
					end
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Registers
	always_ff @(posedge clk) begin
		if (!reset) begin
			enable_q    <= 1'b0;
			int_len_q   <= '0;
			clear_q     <= 1'b0;
			frame_ready <= 1'b0;
			frame_count <= '0;
		end else begin
			clear_q <= wr_en && (reg_sel == CTRL) && pwdata[`CORR_CTRL_CLR_BIT];
			if (wr_en && (reg_sel == CTRL)) begin
				enable_q <= pwdata[`CORR_CTRL_EN_BIT];
			end
			if (wr_en && (reg_sel == INT_LEN)) begin
				int_len_q <= count_t'(pwdata);
			end
			if (res.frame_done) begin
				frame_ready <= 1'b1; // Set wins over a clearing write
			end else if (wr_en && (reg_sel == STATUS) && pwdata[`CORR_STAT_RDY_BIT]) begin
				frame_ready <= 1'b0;
			end
			if (clear_q) begin
				frame_count <= '0;
			end else if (res.frame_done) begin
				frame_count <= frame_count + 1'b1;
			end
		end
	end

	assign res.enable      = enable_q;
	assign res.int_len     = int_len_q;
	assign res.clear_pulse = clear_q;

	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (!reset)
		penable |-> psel
	);

endmodule

/* design/correlator_top.sv */
// One-bit cross-correlator, 4 lines, lags -1..+1, APB readout
// samples must be synchronous to clk; there is no back-pressure

`timescale 1ns/10ps

`include "corr_macros.svh"

module correlator_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`CORR_NUM_INPUTS-1:0] samples,
	input  logic                        sample_valid,
	input  logic [`CORR_APB_ADDR_W-1:0] paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [`CORR_APB_DATA_W-1:0] pwdata,
	output logic [`CORR_APB_DATA_W-1:0] prdata,
	output logic                        pready,
	output logic                        pslverr
);

	sample_if u_sample_if ();
	result_if u_result_if ();

	sample_capture u_capture (
		.clk          (clk),
		.reset        (reset),
		.samples      (samples),
		.sample_valid (sample_valid),
		.cap          (u_sample_if.capture)
	);

	lag_accumulator u_accum (
		.clk   (clk),
		.reset (reset),
		.smp   (u_sample_if.accum),
		.res   (u_result_if.core)
	);

	apb_readout u_apb (
		.clk     (clk),
		.reset   (reset),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.res     (u_result_if.regs)
	);

endmodule

/* test/correlator_tb.sv */
// Testbench for the one-bit correlator, driven over its top-level ports
// Stimulus is driven 1 ns after the rising edge, reads sample mid-cycle
// The reference model keeps its own delay lines and frame counts

`timescale 1ns/10ps

`include "corr_macros.svh"

module correlator_tb
	import corr_pkg::*;
();

	localparam int CLK_PERIOD      = 8;
	localparam int NUM_IN          = `CORR_NUM_INPUTS;
	localparam int NUM_LAGS        = `CORR_NUM_LAGS;
	localparam int NUM_RES         = `CORR_NUM_RESULTS;
	localparam int FRAME_SUM       = 64 + 100 + 3 * 40 + 60;
	localparam int WATCHDOG_CYCLES = FRAME_SUM * 4 + 2000;
	localparam int READY_POLLS     = 20;

	logic                        clk;
	logic                        reset;
	logic [NUM_IN-1:0]           samples;
	logic                        sample_valid;
	logic [`CORR_APB_ADDR_W-1:0] paddr;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [`CORR_APB_DATA_W-1:0] pwdata;
	logic [`CORR_APB_DATA_W-1:0] prdata;
	logic                        pready;
	logic                        pslverr;

	// Reference model state
	logic [`CORR_DEPTH-1:0] m_taps [NUM_IN]; // [0] newest
	int                     cur_counts [NUM_RES];
	int                     exp_bank [NUM_RES];
	int                     m_len_count;
	int                     m_int_len;
	logic                   m_enable;

	logic [31:0] rng;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_start_errors;

	correlator_top u_dut (
		.clk          (clk),
		.reset        (reset),
		.samples      (samples),
		.sample_valid (sample_valid),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// Bus protocol checks
	a_ready_in_access: assert property (
		@(posedge clk) disable iff (!reset)
		(psel && penable) |-> pready
	) else begin
		errors++;
		$display("APB access phase without pready at %0t", $time);
	end

	a_quiet_outside_access: assert property (
		@(posedge clk) disable iff (!reset)
		!penable |-> (!pready && !pslverr)
	) else begin
		errors++;
		$display("pready or pslverr high outside an access phase at %0t", $time);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		assert (actual === expected) else begin
			errors++;
			$display("MISMATCH at %0t: %s read %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// APB master, tasks start and end 1 ns after an edge
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk); // Write lands here
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#2;
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_read(input logic [7:0] addr, input logic [31:0] expected,
		input string what);
		logic [31:0] data;
		logic        err;
		apb_read(addr, data, err);
		check_equal(data, expected, what);
		check_equal(32'(err), 32'd0, {what, " pslverr"});
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model, called once per strobe
	task automatic model_strobe(input logic [NUM_IN-1:0] bits);
		int b;
		for (int i = 0; i < NUM_IN; i++) begin
			m_taps[i] = {m_taps[i][`CORR_DEPTH-2:0], bits[i]};
		end
		if (m_enable) begin
			b = 0;
			for (int i = 0; i < NUM_IN; i++) begin
				for (int j = i + 1; j < NUM_IN; j++) begin
					for (int k = 0; k < NUM_LAGS; k++) begin
						// Lag k-1 pairs line i at age 1 with line j at age k
						if (m_taps[i][1] == m_taps[j][k]) begin
							cur_counts[b * NUM_LAGS + k]++;
						end
					end
					b++;
				end
			end
			m_len_count++;
			if (m_int_len != 0 && m_len_count == m_int_len) begin
				exp_bank = cur_counts;
				foreach (cur_counts[r]) cur_counts[r] = 0;
				m_len_count = 0;
			end
		end
	endtask

	task automatic drive_sample(input logic [NUM_IN-1:0] bits);
		samples      = bits;
		sample_valid = 1'b1;
		@(posedge clk);
		#1;
		sample_valid = 1'b0;
		model_strobe(bits);
	endtask

	task automatic stream_samples(input int n, input bit same_on_all, input int max_gap);
		logic [NUM_IN-1:0] bits;
		int                gap;
		for (int s = 0; s < n; s++) begin
			rng  = xorshift32(rng);
			bits = same_on_all ? {NUM_IN{rng[7]}} : rng[11:8];
			drive_sample(bits);
			gap = (max_gap > 0) ? int'(rng[17:16]) % (max_gap + 1) : 0;
			idle(gap);
		end
	endtask

	// Clear counters and frame count, re-enable, drop frame_ready
	task automatic restart_frames();
		apb_write(CTRL, 32'h3);
		apb_write(STATUS, 32'h1);
		m_enable    = 1'b1;
		m_len_count = 0;
		foreach (cur_counts[r]) cur_counts[r] = 0;
	endtask

	task automatic set_int_len(input int n);
		apb_write(INT_LEN, 32'(n));
		m_int_len = n;
	endtask

	task automatic wait_frame_ready();
		logic [31:0] data;
		logic        err;
		int          polls;
		data  = '0;
		polls = 0;
		while (!data[0] && polls < READY_POLLS) begin
			apb_read(STATUS, data, err);
			polls++;
		end
		assert (data[0]) else begin
			errors++;
			$display("frame_ready did not rise within %0d status reads at %0t", polls, $time);
		end
	endtask

	task automatic check_results(input string tag);
		for (int r = 0; r < NUM_RES; r++) begin
			expect_read(8'(`CORR_RESULT_BASE + 4 * r), 32'(exp_bank[r]),
				$sformatf("%s result %0d", tag, r));
		end
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_start_errors) begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", tests_run, name,
				errors - test_start_errors);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Watchdog
	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : main
		logic [31:0] data;
		logic        err;
		clk          = 1'b0;
		reset        = 1'b0;
		samples      = '0;
		sample_valid = 1'b0;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		rng          = 32'd39;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		m_enable     = 1'b0;
		m_int_len    = 0;
		m_len_count  = 0;
		foreach (m_taps[i]) m_taps[i] = '0;
		foreach (cur_counts[r]) cur_counts[r] = 0;
		foreach (exp_bank[r]) exp_bank[r] = 0;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b1;
		idle(2);

		begin_test();
		expect_read(CTRL, 32'd0, "CTRL");
		expect_read(INT_LEN, 32'd0, "INT_LEN");
		expect_read(STATUS, 32'd0, "STATUS");
		expect_read(FRAME_COUNT, 32'd0, "FRAME_COUNT");
		check_results("reset");
		end_test("reset values");

		begin_test();
		set_int_len(16'h00A5);
		expect_read(INT_LEN, 32'h00A5, "INT_LEN readback");
		apb_write(CTRL, 32'h1);
		m_enable = 1'b1;
		expect_read(CTRL, 32'h1, "CTRL readback");
		apb_read(8'h30, data, err);
		check_equal(32'(err), 32'd1, "pslverr at 0x30");
		apb_read(8'(`CORR_RESULT_BASE + 4 * NUM_RES), data, err);
		check_equal(32'(err), 32'd1, "pslverr past result window");
		end_test("register access");

		begin_test();
		restart_frames();
		set_int_len(64);
		stream_samples(64, 1'b1, 0);
		wait_frame_ready();
		check_results("identical");
		for (int b = 0; b < `CORR_NUM_BASELINES; b++) begin
			expect_read(8'(`CORR_RESULT_BASE + 4 * (b * NUM_LAGS + 1)), 32'd64,
				$sformatf("baseline %0d lag 0", b));
		end
		end_test("identical streams");

		begin_test();
		restart_frames();
		set_int_len(100);
		stream_samples(100, 1'b0, 3);
		wait_frame_ready();
		check_results("independent");
		expect_read(FRAME_COUNT, 32'd1, "FRAME_COUNT after one frame");
		end_test("independent streams");

		begin_test();
		restart_frames();
		set_int_len(40);
		for (int f = 0; f < 3; f++) begin
			stream_samples(40, 1'b0, 1);
			wait_frame_ready();
			check_results($sformatf("frame %0d", f));
			apb_write(STATUS, 32'h1);
		end
		expect_read(STATUS, 32'd0, "STATUS after clearing write");
		expect_read(FRAME_COUNT, 32'd3, "FRAME_COUNT after three frames");
		end_test("back to back frames");

		begin_test();
		set_int_len(60);
		stream_samples(25, 1'b0, 1);
		idle(2);
		apb_write(CTRL, 32'h3); // Clear in mid-frame
		m_len_count = 0;
		foreach (cur_counts[r]) cur_counts[r] = 0;
		expect_read(FRAME_COUNT, 32'd0, "FRAME_COUNT after clear");
		apb_write(CTRL, 32'h0);
		m_enable = 1'b0;
		stream_samples(10, 1'b0, 0); // Shifted but not counted
		idle(2);
		apb_write(CTRL, 32'h1);
		m_enable = 1'b1;
		stream_samples(60, 1'b0, 2);
		wait_frame_ready();
		check_results("after clear");
		expect_read(FRAME_COUNT, 32'd1, "FRAME_COUNT after next frame");
		end_test("clear and disable");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* correlator_top.f */
+incdir+design
design/corr_pkg.sv
design/sample_if.sv
design/result_if.sv
design/sample_capture.sv
design/lag_accumulator.sv
design/apb_readout.sv
design/correlator_top.sv
test/correlator_tb.sv

/* Bender.yml */
package:
  name: correlator

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/corr_pkg.sv
      - design/sample_if.sv
      - design/result_if.sv
      - design/sample_capture.sv
      - design/lag_accumulator.sv
      - design/apb_readout.sv
      - design/correlator_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/correlator_tb.sv
